/* hdl/core_ifs.sv */
// Dispatch and retire interfaces

// One dispatch slot, seen by every block that allocates
interface dispatch_if import isa_pkg::*, core_types_pkg::*; ();

  logic      alloc;    // Dispatch fires this cycle
  arch_idx_t dest;
  inst_t     ir;
  phys_tag_t new_tag;  // From the free list
  phys_tag_t old_tag;  // From the rename table
  rob_idx_t  rob_idx;  // Tail slot of the reorder buffer

  modport control (
    output alloc,
    input  dest
  );

  // Register alias table
  modport rat (
    input  alloc, dest, new_tag,
    output old_tag
  );

  modport list (
    input  alloc, dest,
    output new_tag
  );

  modport rob (
    input  alloc, dest, ir, new_tag, old_tag,
    output rob_idx
  );

  modport regfile (
    input alloc, new_tag
  );

endinterface

// Head of the reorder buffer and the commit strobe
interface retire_if import isa_pkg::*, core_types_pkg::*; ();

  logic      head_done;
  arch_idx_t dest;
  phys_tag_t new_tag;
  phys_tag_t old_tag;
  inst_t     ir;
  logic      commit;  // Head leaves this cycle

  modport control (
    input  head_done, ir,
    output commit
  );

  modport list (
    input commit, dest, old_tag
  );

  modport rob (
    output head_done, dest, new_tag, old_tag, ir,
    input  commit
  );

  modport regfile (
    input new_tag
  );

endinterface

/* hdl/core_macros.svh */
// Core sizing macros

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Reorder buffer entries
`define ROB_DEPTH 16

// Physical register count, tag 0 is the zero register
`define PRF_DEPTH 48

// Architectural register count
`define ARCH_REGS 32

// Tags left over once every architectural register has a mapping
`define FREE_DEPTH (`PRF_DEPTH - `ARCH_REGS)

// Result width
`define XLEN 64

`endif

/* hdl/core_types_pkg.sv */
// Rename core types

`include "core_macros.svh"

package core_types_pkg;

  import isa_pkg::*;

  //////////////////////////////////////////////////
  // Index and data types
  //////////////////////////////////////////////////

  typedef logic [$clog2(`PRF_DEPTH)-1:0] phys_tag_t;
  typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;
  typedef logic [`XLEN-1:0]              data_t;

  // Physical zero register
  localparam phys_tag_t ZERO_TAG = '0;

  //////////////////////////////////////////////////
  // Reorder buffer record
  //////////////////////////////////////////////////

  typedef struct packed {
    arch_idx_t dest;     // Architectural destination
    phys_tag_t new_tag;  // Mapping made at dispatch
    phys_tag_t old_tag;  // Mapping it replaced, freed on commit
    inst_t     ir;
    logic      done;     // Result has been written
  } rob_entry_t;

endpackage

/* hdl/free_list.sv */
// Physical tag free list

`include "core_macros.svh"

module free_list import isa_pkg::*, core_types_pkg::*; (
  input  logic      clock,
  input  logic      rst_n,
  dispatch_if.list  dispatch,
  retire_if.list    retire,
  output logic      list_empty
);

  localparam int PTR_W = $clog2(`FREE_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   cnt_t;

  phys_tag_t slots [`FREE_DEPTH];
  ptr_t      head;   // Next tag handed out
  ptr_t      tail;   // Next slot for a freed tag
  cnt_t      count;
  logic      pop;
  logic      push;

  assign pop  = dispatch.alloc && (dispatch.dest != ZERO_REG);
  assign push = retire.commit && (retire.old_tag != ZERO_TAG);

  assign list_empty       = (count == '0);
  assign dispatch.new_tag = (dispatch.dest == ZERO_REG) ? ZERO_TAG : slots[head];

  //////////////////////////////////////////////////
  // Queue state
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `FREE_DEPTH; i++)
      begin
        slots[i] <= phys_tag_t'(`ARCH_REGS + i);  // Tags 32 .. 47
      end
      head  <= '0;
      tail  <= '0;
      count <= cnt_t'(`FREE_DEPTH);
    end
    else
    begin
      if (push)
      begin
        slots[tail] <= retire.old_tag;
        tail        <= tail + 1'b1;
      end
      if (pop)
        head <= head + 1'b1;
      count <= count + cnt_t'(push) - cnt_t'(pop);
    end
  end

  // Dispatch must have been stalled by the control block
  assert property (@(posedge clock) disable iff (!rst_n)
    pop |-> !list_empty);

  // A real destination always held a real tag before this writer
  assert property (@(posedge clock) disable iff (!rst_n)
    retire.commit && (retire.dest != ZERO_REG) |-> retire.old_tag != ZERO_TAG);

endmodule

/* hdl/isa_pkg.sv */
// Architectural definitions

package isa_pkg;

  //////////////////////////////////////////////////
  // Register file view
  //////////////////////////////////////////////////

  typedef logic [4:0] arch_idx_t;  // r0 .. r31

  // Reads as zero, writes are dropped
  localparam arch_idx_t ZERO_REG = 5'd31;

  //////////////////////////////////////////////////
  // Instruction words
  //////////////////////////////////////////////////

  typedef logic [31:0] inst_t;

  // Stops the core once it commits
  localparam inst_t HALT_INST = 32'h0000_0555;

endpackage

/* hdl/phys_regfile.sv */
// Physical register file

`include "core_macros.svh"

module phys_regfile import core_types_pkg::*; (
  input  logic         clock,
  input  logic         rst_n,
  dispatch_if.regfile  dispatch,
  input  logic         complete_valid,
  input  phys_tag_t    complete_tag,
  input  data_t        complete_value,
  input  phys_tag_t    query_tag,
  output data_t        query_value,
  output logic         query_ready,
  retire_if.regfile    retire,
  output data_t        commit_wr_data
);

  data_t                 values [`PRF_DEPTH];
  logic [`PRF_DEPTH-1:0] ready;  // Value present for this tag

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `PRF_DEPTH; i++)
      begin
        values[i] <= '0;
      end
      ready <= '1;
    end
    else
    begin
      // Fresh tag waits for its producer
      if (dispatch.alloc && (dispatch.new_tag != ZERO_TAG))
        ready[dispatch.new_tag] <= 1'b0;
      if (complete_valid && (complete_tag != ZERO_TAG))
      begin
        values[complete_tag] <= complete_value;
        ready[complete_tag]  <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  assign query_value    = (query_tag == ZERO_TAG) ? '0 : values[query_tag];
  assign query_ready    = (query_tag == ZERO_TAG) || ready[query_tag];
  assign commit_wr_data = (retire.new_tag == ZERO_TAG) ? '0 : values[retire.new_tag];

endmodule

/* hdl/rename_core.sv */
// Rename and retire core

module rename_core import isa_pkg::*, core_types_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  // Dispatch
  input  logic       dispatch_valid,
  output logic       dispatch_ready,
  input  arch_idx_t  dispatch_dest,
  input  inst_t      dispatch_ir,
  output rob_idx_t   dispatch_rob_idx,
  // Completion
  input  logic       complete_valid,
  input  rob_idx_t   complete_rob_idx,
  input  data_t      complete_value,
  // Commit
  output logic       commit_valid,
  output logic       commit_wr_en,
  output arch_idx_t  commit_wr_idx,
  output data_t      commit_wr_data,
  output inst_t      commit_ir,
  output logic       halted,
  // Architectural read port
  input  arch_idx_t  query_idx,
  output data_t      query_value,
  output logic       query_ready
);

  logic      rob_full;
  logic      list_empty;
  phys_tag_t query_tag;
  phys_tag_t complete_tag;

  dispatch_if dispatch_bus ();
  retire_if   retire_bus ();

  assign dispatch_bus.dest = dispatch_dest;
  assign dispatch_bus.ir   = dispatch_ir;
  assign dispatch_rob_idx  = dispatch_bus.rob_idx;

  assign commit_valid  = retire_bus.commit;
  assign commit_wr_en  = retire_bus.commit && (retire_bus.dest != ZERO_REG);
  assign commit_wr_idx = retire_bus.dest;
  assign commit_ir     = retire_bus.ir;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  rename_ctrl ctrl_i (
    .clock(clock), .rst_n(rst_n),
    .dispatch_valid(dispatch_valid), .dispatch_ready(dispatch_ready),
    .rob_full(rob_full), .list_empty(list_empty), .halted(halted),
    .dispatch(dispatch_bus.control), .retire(retire_bus.control)
  );

  rename_table table_i (
    .clock(clock), .rst_n(rst_n), .dispatch(dispatch_bus.rat),
    .query_idx(query_idx), .query_tag(query_tag)
  );

  free_list list_i (
    .clock(clock), .rst_n(rst_n), .dispatch(dispatch_bus.list),
    .retire(retire_bus.list), .list_empty(list_empty)
  );

  reorder_buffer rob_i (
    .clock(clock), .rst_n(rst_n), .dispatch(dispatch_bus.rob),
    .complete_valid(complete_valid), .complete_rob_idx(complete_rob_idx),
    .complete_tag(complete_tag), .retire(retire_bus.rob), .rob_full(rob_full)
  );

  phys_regfile prf_i (
    .clock(clock), .rst_n(rst_n), .dispatch(dispatch_bus.regfile),
    .complete_valid(complete_valid), .complete_tag(complete_tag),
    .complete_value(complete_value), .query_tag(query_tag),
    .query_value(query_value), .query_ready(query_ready),
    .retire(retire_bus.regfile), .commit_wr_data(commit_wr_data)
  );

endmodule

/* hdl/rename_ctrl.sv */
// Dispatch and commit control

module rename_ctrl import isa_pkg::*; (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               dispatch_valid,
  output logic               dispatch_ready,
  input  logic               rob_full,
  input  logic               list_empty,
  output logic               halted,
  dispatch_if.control        dispatch,
  retire_if.control          retire
);

  logic needs_tag;  // Destination takes a tag from the free list

  //////////////////////////////////////////////////
  // Dispatch
  //////////////////////////////////////////////////

  assign needs_tag = (dispatch.dest != ZERO_REG);

  // r31 never renames, so an empty free list does not stall it
  assign dispatch_ready = !rob_full && !(list_empty && needs_tag) && !halted;
  assign dispatch.alloc = dispatch_valid && dispatch_ready;

  //////////////////////////////////////////////////
  // Commit and halt
  //////////////////////////////////////////////////

  assign retire.commit = retire.head_done && !halted;

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      halted <= 1'b0;
    end
    else if (retire.commit && (retire.ir == HALT_INST))
    begin
      halted <= 1'b1;  // Held until reset
    end
  end

  // The free list only runs dry when every reorder buffer slot holds a renamed tag
  assert property (@(posedge clock) disable iff (!rst_n)
    list_empty |-> rob_full);

endmodule

/* hdl/rename_table.sv */
// Register alias table

`include "core_macros.svh"

module rename_table import isa_pkg::*, core_types_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  dispatch_if.rat    dispatch,
  input  arch_idx_t  query_idx,
  output phys_tag_t  query_tag
);

  phys_tag_t map_q [`ARCH_REGS];  // Youngest mapping per register
  logic      map_we;

  // r31 is never written, it keeps ZERO_TAG from reset
  assign map_we = dispatch.alloc && (dispatch.dest != ZERO_REG);

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // r maps to tag r+1, r31 to the zero tag
      for (int i = 0; i < `ARCH_REGS; i++)
      begin
        if (i == int'(ZERO_REG))
          map_q[i] <= ZERO_TAG;
        else
          map_q[i] <= phys_tag_t'(i + 1);
      end
    end
    else if (map_we)
    begin
      map_q[dispatch.dest] <= dispatch.new_tag;
    end
  end

  //////////////////////////////////////////////////
  // Lookups
  //////////////////////////////////////////////////

  // Tag being replaced, goes into the reorder buffer
  assign dispatch.old_tag = map_q[dispatch.dest];

  assign query_tag = map_q[query_idx];  // Architectural read port

endmodule

/* hdl/reorder_buffer.sv */
// Reorder buffer

`include "core_macros.svh"

module reorder_buffer import core_types_pkg::*; (
  input  logic        clock,
  input  logic        rst_n,
  dispatch_if.rob     dispatch,
  input  logic        complete_valid,
  input  rob_idx_t    complete_rob_idx,
  output phys_tag_t   complete_tag,
  retire_if.rob       retire,
  output logic        rob_full
);

  localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

  typedef logic [CNT_W-1:0] cnt_t;

  rob_entry_t entries [`ROB_DEPTH];
  rob_idx_t   head;
  rob_idx_t   tail;
  cnt_t       count;
  rob_idx_t   complete_ofs;   // Distance of the completing entry from head
  logic       complete_live;  // Completing entry is between head and tail
  rob_entry_t head_entry;

  //////////////////////////////////////////////////
  // Pointers
  //////////////////////////////////////////////////

  assign rob_full         = (count == cnt_t'(`ROB_DEPTH));
  assign dispatch.rob_idx = tail;

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end
    else
    begin
      if (dispatch.alloc)
        tail <= tail + 1'b1;
      if (retire.commit)
        head <= head + 1'b1;
      count <= count + cnt_t'(dispatch.alloc) - cnt_t'(retire.commit);
    end
  end

  //////////////////////////////////////////////////
  // Entry storage
  //////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (dispatch.alloc)
    begin
      entries[tail].dest    <= dispatch.dest;
      entries[tail].new_tag <= dispatch.new_tag;
      entries[tail].old_tag <= dispatch.old_tag;
      entries[tail].ir      <= dispatch.ir;
      entries[tail].done    <= 1'b0;
    end
    if (complete_valid)
      entries[complete_rob_idx].done <= 1'b1;  // Only an older entry, never the tail
  end

  // Result bus tag for the physical register file
  assign complete_tag = entries[complete_rob_idx].new_tag;

  //////////////////////////////////////////////////
  // Head presented for commit
  //////////////////////////////////////////////////

  assign head_entry = entries[head];

  // Stale records past the tail are masked by the count
  assign retire.head_done = (count != '0) && head_entry.done;
  assign retire.dest      = head_entry.dest;
  assign retire.new_tag   = head_entry.new_tag;
  assign retire.old_tag   = head_entry.old_tag;
  assign retire.ir        = head_entry.ir;

  assign complete_ofs  = complete_rob_idx - head;
  assign complete_live = (cnt_t'(complete_ofs) < count);

  // The result bus only names in-flight entries, and each only once
  assert property (@(posedge clock) disable iff (!rst_n)
    complete_valid |-> complete_live && !entries[complete_rob_idx].done);

endmodule

/* project.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/core_types_pkg.sv
hdl/core_ifs.sv
hdl/rename_ctrl.sv
hdl/rename_table.sv
hdl/free_list.sv
hdl/reorder_buffer.sv
hdl/phys_regfile.sv
hdl/rename_core.sv
sim/rename_checker.sv
sim/rename_core_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module rename_core_tb -f project.f -o rename_core_sim > build.log 2>&1 \
  && ./obj_dir/rename_core_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sim/rename_checker.sv */
// Rename core reference model

module rename_checker import isa_pkg::*, core_types_pkg::*; (
  input  logic      clock,
  input  logic      rst_n,
  input  logic      dispatch_valid,
  input  logic      dispatch_ready,
  input  arch_idx_t dispatch_dest,
  input  inst_t     dispatch_ir,
  input  rob_idx_t  dispatch_rob_idx,
  input  logic      complete_valid,
  input  rob_idx_t  complete_rob_idx,
  input  data_t     complete_value,
  input  logic      commit_valid,
  input  logic      commit_wr_en,
  input  arch_idx_t commit_wr_idx,
  input  data_t     commit_wr_data,
  input  inst_t     commit_ir,
  input  logic      halted,
  input  arch_idx_t query_idx,
  input  data_t     query_value,
  input  logic      query_ready,
  output int        error_count,
  output int        check_count
);

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [31:0] seq;      // Dispatch order
    arch_idx_t   dest;
    inst_t       ir;
    rob_idx_t    rob_idx;
    logic        done;
    data_t       value;
  } flight_t;

  flight_t     flights[$];       // In flight, oldest first
  int          youngest [32];    // Sequence of the youngest writer
  logic        arch_ready [32];
  data_t       arch_value [32];  // r31 is never written and stays 0
  logic        model_halted;
  logic [31:0] next_seq;
  logic        exp_ready;
  logic        exp_commit;

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic reset_model();
    flights.delete();
    for (int r = 0; r < 32; r++)
    begin
      youngest[r]   = -1;
      arch_ready[r] = 1'b1;
      arch_value[r] = '0;
    end
    model_halted = 1'b0;
    next_seq     = '0;
    error_count  = 0;
    check_count  = 0;
  endtask

  //////////////////////////////////////////////////
  // Outputs before the edge
  //////////////////////////////////////////////////

  task automatic check_outputs();
    flight_t head;
    // Free list cannot run dry before the ROB fills
    exp_ready  = !model_halted && (flights.size() < 16);
    exp_commit = 1'b0;
    if (!model_halted && (flights.size() > 0))
      exp_commit = flights[0].done;
    compare("dispatch_ready", dispatch_ready, exp_ready);
    compare("halted", halted, model_halted);
    compare("commit_valid", commit_valid, exp_commit);
    if (exp_commit)
    begin
      head = flights[0];
      compare("commit_wr_idx", commit_wr_idx, head.dest);
      compare("commit_ir", commit_ir, head.ir);
      compare("commit_wr_en", commit_wr_en, head.dest != ZERO_REG);
      compare("commit_wr_data", commit_wr_data, (head.dest == ZERO_REG) ? '0 : head.value);
    end
    else
      compare("commit_wr_en", commit_wr_en, 1'b0);  // No write without a commit
    compare("query_ready", query_ready, arch_ready[query_idx]);
    if (arch_ready[query_idx])
      compare("query_value", query_value, arch_value[query_idx]);
    if (dispatch_valid && exp_ready)
      compare("dispatch_rob_idx", dispatch_rob_idx, rob_idx_t'(next_seq));  // In order slots
  endtask

  //////////////////////////////////////////////////
  // Model update at the edge
  //////////////////////////////////////////////////

  task automatic apply_edge();
    flight_t e;
    int      hit;
    if (exp_commit)
    begin
      if (flights[0].ir == HALT_INST)
        model_halted = 1'b1;
      e = flights.pop_front();
    end
    if (complete_valid)
    begin
      hit = -1;
      foreach (flights[i])
        if ((flights[i].rob_idx == complete_rob_idx) && !flights[i].done)
          hit = i;
      if (hit < 0)
      begin
        error_count++;
        $display("Completion of ROB entry %0d matches no pending instruction", complete_rob_idx);
      end
      else
      begin
        e       = flights[hit];
        e.done  = 1'b1;
        e.value = complete_value;
        flights[hit] = e;
        if (youngest[e.dest] == int'(e.seq))  // Older writers stay hidden
        begin
          arch_ready[e.dest] = 1'b1;
          arch_value[e.dest] = complete_value;
        end
      end
    end
    if (dispatch_valid && exp_ready)
    begin
      e.seq     = next_seq;
      e.dest    = dispatch_dest;
      e.ir      = dispatch_ir;
      e.rob_idx = rob_idx_t'(next_seq);
      e.done    = 1'b0;
      e.value   = '0;
      flights.push_back(e);
      if (dispatch_dest != ZERO_REG)
      begin
        youngest[dispatch_dest]   = int'(next_seq);
        arch_ready[dispatch_dest] = 1'b0;
      end
      next_seq++;
    end
  endtask

  always @(posedge clock)
  begin
    if (!rst_n)
      reset_model();
    else
    begin
      check_outputs();
      apply_edge();
    end
  end

endmodule

/* sim/rename_core_tb.sv */
// Rename core testbench

module rename_core_tb import isa_pkg::*, core_types_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED = 32'h8e89;
  localparam int NO_COMPLETE     = 0;
  localparam int COMPLETE_ANY    = 1;
  localparam int COMPLETE_OLDEST = 2;
  localparam int WAIT_LIMIT      = 200;   // Cycles for a short wait
  localparam int RUN_LIMIT       = 5000;  // Cycles for the random run

  logic      clock;
  logic      rst_n;
  logic      dispatch_valid;
  logic      dispatch_ready;
  arch_idx_t dispatch_dest;
  inst_t     dispatch_ir;
  rob_idx_t  dispatch_rob_idx;
  logic      complete_valid;
  rob_idx_t  complete_rob_idx;
  data_t     complete_value;
  logic      commit_valid;
  logic      commit_wr_en;
  arch_idx_t commit_wr_idx;
  data_t     commit_wr_data;
  inst_t     commit_ir;
  logic      halted;
  arch_idx_t query_idx;
  data_t     query_value;
  logic      query_ready;

  logic [31:0] rng_state;
  rob_idx_t    pending[$];  // Dispatched, not completed
  arch_idx_t   probe_idx;   // Read port address for the next cycle
  logic        last_fired;
  data_t       last_value;
  int          dispatched;
  int          committed;
  int          tb_errors;
  int          tb_checks;
  int          checker_errors;
  int          checker_checks;
  int          errors_before;  // Total at the start of the current test

  rename_core rename_core_i (.*);

  rename_checker checker_i (.*, .error_count(checker_errors), .check_count(checker_checks));

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  //////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic arch_idx_t pick_dest();
    logic [31:0] r;
    r = next_rand();
    if (r[31:30] == 2'b00)
      return ZERO_REG;  // A quarter of the time
    return arch_idx_t'(r[23:16] % 8'd31);
  endfunction

  function automatic inst_t pick_ir();
    logic [31:0] r;
    r = next_rand();
    if (r == HALT_INST)
      r = r ^ 32'h1;
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Stimulus and checks
  //////////////////////////////////////////////////

  task automatic check_signal(input string name, input logic [63:0] got, input logic [63:0] exp);
    tb_checks++;
    if (got !== exp)
    begin
      tb_errors++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_timeout(input string what);
    tb_errors++;
    $display("Timed out waiting for %s", what);
  endtask

  // Drive at the falling edge, note what happened at the rising edge
  task automatic run_cycle(input logic send, input arch_idx_t dest, input inst_t ir,
                           input int mode);
    logic [31:0] r;
    int          k;
    @(negedge clock);
    dispatch_valid = send;
    dispatch_dest  = dest;
    dispatch_ir    = ir;
    query_idx      = probe_idx;
    complete_valid = 1'b0;
    if ((mode != NO_COMPLETE) && (pending.size() > 0))
    begin
      r = next_rand();
      k = (mode == COMPLETE_OLDEST) ? 0 : int'(r[31:16]) % pending.size();
      complete_valid          = 1'b1;
      complete_rob_idx        = pending[k];
      complete_value[63:32]   = next_rand();
      complete_value[31:0]    = next_rand();
      last_value              = complete_value;
      pending.delete(k);
    end
    @(posedge clock);
    last_fired = send && dispatch_ready;
    if (last_fired)
    begin
      pending.push_back(dispatch_rob_idx);
      dispatched++;
    end
    if (commit_valid)
      committed++;
  endtask

  task automatic send_one(input arch_idx_t dest, input inst_t ir);
    int cycles;
    cycles     = 0;
    last_fired = 1'b0;
    while (!last_fired && (cycles < WAIT_LIMIT))
    begin
      run_cycle(1'b1, dest, ir, NO_COMPLETE);
      cycles++;
    end
    if (!last_fired)
      report_timeout("a dispatch to be accepted");
  endtask

  task automatic wait_for_commit(input int mode);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && (cycles < WAIT_LIMIT))
    begin
      run_cycle(1'b0, '0, '0, mode);
      seen = commit_valid;
      cycles++;
    end
    if (!seen)
      report_timeout("an instruction to commit");
  endtask

  task automatic drain(input int limit);
    int cycles;
    cycles = 0;
    while ((committed < dispatched) && (cycles < limit))
    begin
      run_cycle(1'b0, '0, '0, COMPLETE_ANY);
      cycles++;
    end
    if (committed < dispatched)
      report_timeout("the reorder buffer to drain");
  endtask

  task automatic close_test(input int num, input string name);
    int total;
    @(negedge clock);
    dispatch_valid = 1'b0;
    complete_valid = 1'b0;
    total = tb_errors + checker_errors;
    if (total == errors_before)
      $display("test %0d %s: passed", num, name);
    else
      $display("test %0d %s: failed, %0d errors", num, name, total - errors_before);
    errors_before = total;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    int          cycles;
    int          target;
    logic        seen;
    logic [31:0] r;
    rng_state        = SEED;
    rst_n            = 1'b0;
    dispatch_valid   = 1'b0;
    dispatch_dest    = '0;
    dispatch_ir      = '0;
    complete_valid   = 1'b0;
    complete_rob_idx = '0;
    complete_value   = '0;
    query_idx        = '0;
    probe_idx        = '0;
    last_fired       = 1'b0;
    last_value       = '0;
    dispatched       = 0;
    committed        = 0;
    tb_errors        = 0;
    tb_checks        = 0;
    errors_before    = 0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;

    // Every register reads zero after reset
    for (int i = 0; i < 32; i++)
    begin
      probe_idx = arch_idx_t'(i);
      run_cycle(1'b0, '0, '0, NO_COMPLETE);
      check_signal("query_value", query_value, '0);
      check_signal("query_ready", query_ready, 1'b1);
      check_signal("dispatch_ready", dispatch_ready, 1'b1);
      check_signal("commit_valid", commit_valid, 1'b0);
      check_signal("halted", halted, 1'b0);
    end
    close_test(1, "reset state");

    cycles = 0;
    target = dispatched + 300;
    while ((dispatched < target) && (cycles < RUN_LIMIT))
    begin
      r         = next_rand();
      probe_idx = r[12:8];
      run_cycle(r[31:30] != 2'b00, pick_dest(), pick_ir(),
                (r[29:28] != 2'b00) ? COMPLETE_ANY : NO_COMPLETE);
      cycles++;
    end
    if (dispatched < target)
      report_timeout("300 random dispatches");
    drain(WAIT_LIMIT * 4);
    close_test(2, "random dispatch and completion");

    probe_idx = ZERO_REG;
    send_one(ZERO_REG, pick_ir());
    wait_for_commit(COMPLETE_ANY);
    check_signal("commit_wr_idx", commit_wr_idx, ZERO_REG);
    check_signal("commit_wr_en", commit_wr_en, 1'b0);
    check_signal("query_value", query_value, '0);
    check_signal("query_ready", query_ready, 1'b1);
    close_test(3, "zero register");

    probe_idx = 5'd5;
    send_one(5'd5, pick_ir());
    run_cycle(1'b0, '0, '0, NO_COMPLETE);
    check_signal("query_ready", query_ready, 1'b0);  // Writer still pending
    run_cycle(1'b0, '0, '0, COMPLETE_OLDEST);
    run_cycle(1'b0, '0, '0, NO_COMPLETE);
    check_signal("query_ready", query_ready, 1'b1);
    check_signal("query_value", query_value, last_value);
    drain(WAIT_LIMIT);
    run_cycle(1'b0, '0, '0, NO_COMPLETE);
    check_signal("query_value", query_value, last_value);
    close_test(4, "read port");

    for (int i = 0; i < 16; i++)
      send_one(pick_dest(), pick_ir());
    for (int i = 0; i < 5; i++)
    begin
      run_cycle(1'b1, pick_dest(), pick_ir(), NO_COMPLETE);
      check_signal("dispatch_ready", dispatch_ready, 1'b0);
    end
    run_cycle(1'b0, '0, '0, COMPLETE_OLDEST);  // Frees the head
    cycles = 0;
    seen   = 1'b0;
    while (!seen && (cycles < WAIT_LIMIT))
    begin
      run_cycle(1'b0, '0, '0, NO_COMPLETE);
      seen = dispatch_ready;
      cycles++;
    end
    if (!seen)
      report_timeout("dispatch_ready after a commit");
    drain(WAIT_LIMIT);
    close_test(5, "full reorder buffer");

    send_one(pick_dest(), HALT_INST);
    send_one(pick_dest(), pick_ir());
    send_one(pick_dest(), pick_ir());
    cycles = 0;
    seen   = 1'b0;
    while (!seen && (cycles < WAIT_LIMIT))
    begin
      run_cycle(1'b0, '0, '0, COMPLETE_ANY);
      seen = halted;
      cycles++;
    end
    if (!seen)
      report_timeout("the core to halt");
    for (int i = 0; i < 10; i++)
    begin
      run_cycle(1'b1, pick_dest(), pick_ir(), NO_COMPLETE);
      check_signal("halted", halted, 1'b1);
      check_signal("commit_valid", commit_valid, 1'b0);
      check_signal("dispatch_ready", dispatch_ready, 1'b0);
    end
    close_test(6, "halt");

    $display("6 tests, %0d checks, %0d errors", tb_checks + checker_checks,
             tb_errors + checker_errors);
    if ((tb_errors + checker_errors) == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule
